/* verilog/pipeline16_pkg.sv */
`default_nettype none

package pipeline16_pkg;

	typedef logic [15:0] word_t;		// data, address and instruction word
	typedef logic [4:0]  reg_addr_t;	// 0..15 name a register, 16 is none
	typedef logic [11:0] imm_hi_t;		// upper immediate from a 1iii prefix
	typedef logic [3:0]  imm_lo_t;
	typedef logic [3:0]  alu_op_t;

	localparam reg_addr_t REG_NONE        = 5'd16;
	localparam word_t     NOP_INSTRUCTION = 16'h0000;

	typedef enum logic [2:0] {
		CLS_NOP,
		CLS_IMM,
		CLS_ALU_RR,
		CLS_ALU_RI,
		CLS_LOAD,
		CLS_STORE,
		CLS_OTHER		// unused encodings, executed as a nop
	} ins_class_t;

	function automatic ins_class_t ins_class(input word_t ins);
		ins_class_t cls;
		case (ins[15:12])
			4'h0:    cls = (ins == NOP_INSTRUCTION) ? CLS_NOP : CLS_OTHER;
			4'h1:    cls = CLS_IMM;
			4'h2:    cls = CLS_ALU_RR;
			4'h3:    cls = CLS_ALU_RI;
			4'h6:    cls = ins[8] ? CLS_STORE : CLS_LOAD;	// bit 8 set means store
			default: cls = CLS_OTHER;
		endcase
		return cls;
	endfunction

	function automatic reg_addr_t field_dest(input word_t ins);
		return {1'b0, ins[7:4]};
	endfunction

	function automatic reg_addr_t field_src(input word_t ins);
		return {1'b0, ins[3:0]};
	endfunction

	function automatic alu_op_t field_alu_op(input word_t ins);
		return ins[11:8];
	endfunction

	function automatic imm_hi_t field_imm_hi(input word_t ins);
		return ins[11:0];
	endfunction

	function automatic imm_lo_t field_imm_lo(input word_t ins);
		return ins[3:0];
	endfunction

	// register written back by the instruction, if any
	function automatic reg_addr_t write_addr(input word_t ins);
		ins_class_t cls;
		cls = ins_class(ins);
		if ((cls == CLS_ALU_RR) || (cls == CLS_ALU_RI) || (cls == CLS_LOAD))
			return field_dest(ins);
		return REG_NONE;
	endfunction

	// port a read: alu ops read their destination, a store reads its data register
	function automatic reg_addr_t read_a_addr(input word_t ins);
		ins_class_t cls;
		cls = ins_class(ins);
		if ((cls == CLS_ALU_RR) || (cls == CLS_ALU_RI) || (cls == CLS_STORE))
			return field_dest(ins);
		return REG_NONE;
	endfunction

	function automatic reg_addr_t read_b_addr(input word_t ins);
		return (ins_class(ins) == CLS_ALU_RR) ? field_src(ins) : REG_NONE;
	endfunction

endpackage

`default_nettype wire

/* verilog/pipeline16_stage_if.sv */
`default_nettype none

// instruction entering execute (S2)
interface decode_if import pipeline16_pkg::*; ();
	word_t      ins;	// S2 instruction register
	ins_class_t cls;
	word_t      imm;	// prefix followed by the low nibble
	reg_addr_t  dest;	// write-back register or none

	modport driver (output ins, cls, imm, dest);
	modport receiver (input ins, cls, imm, dest);
endinterface

// instruction leaving execute (S3)
interface exec_if import pipeline16_pkg::*; ();
	ins_class_t cls;
	reg_addr_t  dest;
	word_t      ls_addr;	// load/store address
	word_t      store_data;

	modport driver (output cls, dest, ls_addr, store_data);
	modport receiver (input cls, dest, ls_addr, store_data);
endinterface

`default_nettype wire

/* verilog/pipeline16_decode.sv */
`default_nettype none

module pipeline16_decode import pipeline16_pkg::*; #(
	parameter word_t RESET_PC = 16'h0000
) (
	input  wire         CLK,
	input  wire         RSTb,
	input  wire word_t  memory_in,
	input  wire         stall_hold,		// keep the pc, the fetched word gets refetched
	input  wire         stall_bubble,	// hold S0/S1, nop into S2
	input  wire         mem_slot,
	input  wire         mem_access,
	output word_t       ins_s0,
	output word_t       pc,
	output reg_addr_t   reg_a_addr,
	output reg_addr_t   reg_b_addr,
	decode_if.driver    dec
);

	word_t      ins_s1;
	imm_hi_t    imm_prefix;
	ins_class_t cls_s1;

	assign cls_s1 = ins_class(ins_s1);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pc         <= RESET_PC;
			ins_s0     <= NOP_INSTRUCTION;
			ins_s1     <= NOP_INSTRUCTION;
			imm_prefix <= '0;
			dec.ins    <= NOP_INSTRUCTION;
			dec.cls    <= CLS_NOP;
			dec.dest   <= REG_NONE;
			reg_a_addr <= REG_NONE;
			reg_b_addr <= REG_NONE;
		end else begin
			// the port belongs to the load/store in S3, or the next word would be dropped
			if (!(stall_hold || mem_access))
				pc <= pc + 16'd1;

			if (stall_bubble) begin
				dec.ins    <= NOP_INSTRUCTION;
				dec.cls    <= CLS_NOP;
				dec.dest   <= REG_NONE;
				reg_a_addr <= REG_NONE;
				reg_b_addr <= REG_NONE;
			end else begin
				ins_s0 <= mem_slot ? NOP_INSTRUCTION : memory_in;	// data slot is not code
				ins_s1 <= ins_s0;

				dec.ins  <= ins_s1;
				dec.cls  <= cls_s1;
				dec.dest <= write_addr(ins_s1);

				// read addresses travel with S2 so the data is there during execute
				reg_a_addr <= read_a_addr(ins_s1);
				reg_b_addr <= read_b_addr(ins_s1);

				if (cls_s1 == CLS_IMM)
					imm_prefix <= field_imm_hi(ins_s1);
				else if (cls_s1 != CLS_NOP)
					imm_prefix <= '0;	// a prefix only covers the next instruction
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!stall_bubble)
			dec.imm <= {imm_prefix, field_imm_lo(ins_s1)};
	end

endmodule

`default_nettype wire

/* verilog/pipeline16_interlock.sv */
`default_nettype none

module pipeline16_interlock import pipeline16_pkg::*; #(
	parameter int STALL_MAX = 4
) (
	input  wire         CLK,
	input  wire         RSTb,
	input  wire word_t  ins_s0,
	output logic        stall_hold,
	output logic        stall_bubble
);

	localparam int CNT_W = $clog2(STALL_MAX + 1);

	reg_addr_t        hazard1;	// destination now in S1
	reg_addr_t        hazard2;	// in S2
	reg_addr_t        hazard3;	// in S3
	reg_addr_t        src_a;
	reg_addr_t        src_b;
	logic [CNT_W-1:0] stall_cnt;
	logic [CNT_W-1:0] stall_cnt_next;

	function automatic logic reads(input reg_addr_t hz, input reg_addr_t a, input reg_addr_t b);
		return (hz != REG_NONE) && ((hz == a) || (hz == b));
	endfunction

	assign src_a = read_a_addr(ins_s0);
	assign src_b = read_b_addr(ins_s0);

	assign stall_bubble = (stall_cnt > CNT_W'(1));
	assign stall_hold   = (stall_cnt_next > CNT_W'(1));	// one cycle ahead, for the pc

	always_comb begin
		stall_cnt_next = (stall_cnt != '0) ? stall_cnt - CNT_W'(1) : stall_cnt;

		// newest producer first, it needs the longest wait
		if (!stall_bubble) begin
			if (reads(hazard1, src_a, src_b))
				stall_cnt_next = CNT_W'(STALL_MAX);
			else if (reads(hazard2, src_a, src_b))
				stall_cnt_next = CNT_W'(STALL_MAX - 1);
			else if (reads(hazard3, src_a, src_b))
				stall_cnt_next = CNT_W'(STALL_MAX - 2);
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			hazard1   <= REG_NONE;
			hazard2   <= REG_NONE;
			hazard3   <= REG_NONE;
			stall_cnt <= '0;
		end else begin
			stall_cnt <= stall_cnt_next;
			hazard3   <= hazard2;
			if (stall_bubble) begin
				hazard2 <= REG_NONE;	// S1 held, nop goes into S2
			end else begin
				hazard1 <= write_addr(ins_s0);
				hazard2 <= hazard1;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/pipeline16_execute.sv */
`default_nettype none

module pipeline16_execute import pipeline16_pkg::*; (
	input  wire         CLK,
	input  wire         RSTb,
	input  wire word_t  reg_a,
	input  wire word_t  reg_b,
	output alu_op_t     alu_op,
	output word_t       alu_a,
	output word_t       alu_b,
	decode_if.receiver  dec,
	exec_if.driver      exe
);

	logic is_alu;

	assign is_alu = (dec.cls == CLS_ALU_RR) || (dec.cls == CLS_ALU_RI);

	// alu sees S2 directly, result comes back two cycles later in S4
	assign alu_op = is_alu ? field_alu_op(dec.ins) : alu_op_t'(0);
	assign alu_a  = reg_a;
	assign alu_b  = (dec.cls == CLS_ALU_RI) ? dec.imm : reg_b;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			exe.cls  <= CLS_NOP;
			exe.dest <= REG_NONE;
		end else begin
			exe.cls  <= dec.cls;
			exe.dest <= dec.dest;
		end
	end

	always_ff @(posedge CLK) begin
		exe.ls_addr    <= dec.imm;		// immediate address only
		exe.store_data <= reg_a;		// store data is the register named in 7:4
	end

endmodule

`default_nettype wire

/* verilog/pipeline16_result.sv */
`default_nettype none

module pipeline16_result import pipeline16_pkg::*; (
	input  wire         CLK,
	input  wire         RSTb,
	input  wire word_t  pc,
	input  wire word_t  memory_in,
	input  wire word_t  alu_out,
	exec_if.receiver    exe,
	output word_t       memory_addr,
	output word_t       memory_out,
	output logic        mem_rd,
	output logic        mem_wr,
	output logic        mem_slot,
	output logic        mem_access,
	output reg_addr_t   reg_wr_addr,
	output word_t       reg_wr_data
);

	ins_class_t cls_s4;
	reg_addr_t  dest_s4;

	// S3 takes the memory port for a load or store, otherwise fetch
	assign mem_access  = (exe.cls == CLS_LOAD) || (exe.cls == CLS_STORE);
	assign memory_addr = mem_access ? exe.ls_addr : pc;
	assign mem_wr      = (exe.cls == CLS_STORE);
	assign mem_rd      = !mem_wr;
	assign memory_out  = exe.store_data;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			cls_s4   <= CLS_NOP;
			dest_s4  <= REG_NONE;
			mem_slot <= 1'b1;	// word on memory_in right after reset is a stale read
		end else begin
			cls_s4   <= exe.cls;
			dest_s4  <= exe.dest;
			mem_slot <= mem_access;
		end
	end

	// write-back from S4, load data arrives one cycle after S3
	always_comb begin
		reg_wr_addr = REG_NONE;
		reg_wr_data = alu_out;
		case (cls_s4)
			CLS_ALU_RR, CLS_ALU_RI: begin
				reg_wr_addr = dest_s4;
			end
			CLS_LOAD: begin
				reg_wr_addr = dest_s4;
				reg_wr_data = memory_in;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/pipeline16.sv */
`default_nettype none

module pipeline16 import pipeline16_pkg::*; #(
	parameter int    STALL_MAX = 4,			// longest interlock stall
	parameter word_t RESET_PC  = 16'h0000
) (
	input  wire         CLK,
	input  wire         RSTb,

	output alu_op_t     alu_op,
	output word_t       alu_a,
	output word_t       alu_b,
	input  wire word_t  alu_out,	// two cycles after the operands

	output reg_addr_t   reg_a_addr,
	output reg_addr_t   reg_b_addr,
	input  wire word_t  reg_a,
	input  wire word_t  reg_b,
	output reg_addr_t   reg_wr_addr,
	output word_t       reg_wr_data,

	output word_t       memory_addr,
	output word_t       memory_out,
	output logic        mem_rd,
	output logic        mem_wr,
	input  wire word_t  memory_in
);

	word_t ins_s0;
	word_t pc;
	logic  stall_hold;
	logic  stall_bubble;
	logic  mem_slot;
	logic  mem_access;

	decode_if dec_bus ();
	exec_if   exe_bus ();

	pipeline16_decode #(
		.RESET_PC (RESET_PC)
	) decode_i (
		.CLK          (CLK),
		.RSTb         (RSTb),
		.memory_in    (memory_in),
		.stall_hold   (stall_hold),
		.stall_bubble (stall_bubble),
		.mem_slot     (mem_slot),
		.mem_access   (mem_access),
		.ins_s0       (ins_s0),
		.pc           (pc),
		.reg_a_addr   (reg_a_addr),
		.reg_b_addr   (reg_b_addr),
		.dec          (dec_bus)
	);

	pipeline16_interlock #(
		.STALL_MAX (STALL_MAX)
	) interlock_i (
		.CLK          (CLK),
		.RSTb         (RSTb),
		.ins_s0       (ins_s0),
		.stall_hold   (stall_hold),
		.stall_bubble (stall_bubble)
	);

	pipeline16_execute execute_i (
		.CLK    (CLK),
		.RSTb   (RSTb),
		.reg_a  (reg_a),
		.reg_b  (reg_b),
		.alu_op (alu_op),
		.alu_a  (alu_a),
		.alu_b  (alu_b),
		.dec    (dec_bus),
		.exe    (exe_bus)
	);

	pipeline16_result result_i (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.pc          (pc),
		.memory_in   (memory_in),
		.alu_out     (alu_out),
		.exe         (exe_bus),
		.memory_addr (memory_addr),
		.memory_out  (memory_out),
		.mem_rd      (mem_rd),
		.mem_wr      (mem_wr),
		.mem_slot    (mem_slot),
		.mem_access  (mem_access),
		.reg_wr_addr (reg_wr_addr),
		.reg_wr_data (reg_wr_data)
	);

endmodule

`default_nettype wire

/* dv/pipeline16_tb.sv */
`default_nettype none

module pipeline16_tb import pipeline16_pkg::*; ();

	localparam int    STALL_MAX    = 4;
	localparam int    CLK_PERIOD   = 20;
	localparam int    RESET_CYCLES = 10;
	localparam int    PROG_LEN     = 64;
	localparam int    DRAIN_CYCLES = 12;
	localparam word_t DATA_BASE    = 16'h4000;	// loads and stores land here, far above code
	localparam int    WATCHDOG     = (RESET_CYCLES + PROG_LEN * (STALL_MAX + 2)) * CLK_PERIOD;

	logic      CLK       = 1'b0;
	logic      RSTb;
	alu_op_t   alu_op;
	word_t     alu_a;
	word_t     alu_b;
	word_t     alu_out   = '0;
	word_t     alu_pipe  = '0;	// first stage of the two-cycle alu
	reg_addr_t reg_a_addr;
	reg_addr_t reg_b_addr;
	word_t     reg_a;
	word_t     reg_b;
	reg_addr_t reg_wr_addr;
	word_t     reg_wr_data;
	word_t     memory_addr;
	word_t     memory_out;
	logic      mem_rd;
	logic      mem_wr;
	word_t     memory_in = '0;

	word_t       mem [0:65535];
	word_t       rf [0:15];
	word_t       prog [0:PROG_LEN-1];
	logic [31:0] lfsr;
	reg_addr_t   exp_wr_addr [$];
	word_t       exp_wr_data [$];
	word_t       exp_st_addr [$];
	word_t       exp_st_data [$];

	pipeline16 #(
		.STALL_MAX (STALL_MAX),
		.RESET_PC  (16'h0000)
	) pipeline16_i (.*);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int unsigned rand_bits(input int n);
		int unsigned v;
		int          i;
		v = 0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = (v << 1) | lfsr[0];
		end
		return v;
	endfunction

	function automatic word_t alu_calc(input alu_op_t op, input word_t a, input word_t b);
		case (op)
			4'd0:    return a + b;
			4'd1:    return a - b;
			4'd2:    return a & b;
			4'd3:    return a | b;
			4'd4:    return a ^ b;
			4'd5:    return b;	// mov
			default: return '0;
		endcase
	endfunction

	function automatic word_t fill_word(input word_t a);
		return (a * 16'h9e37) ^ {a[7:0], a[15:8]};
	endfunction

	task automatic stop_on_failure();
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("error %s = %h, expected %h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_reg_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
		if (got !== exp) begin
			$display("error %s = %h, expected %h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error %s = %h, expected %h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic build_program();
		int         pc;
		int         kind;
		logic [3:0] rd;
		logic [3:0] lo;
		alu_op_t    op;
		pc = 0;
		while (pc < PROG_LEN) begin
			kind = rand_bits(3);
			rd   = 4'(rand_bits(3));	// few registers, so hazards come often
			lo   = 4'(rand_bits(4));
			op   = alu_op_t'(rand_bits(3) % 6);
			if ((kind == 5 || kind == 6) && (pc < PROG_LEN - 1)) begin
				prog[pc]     = {4'h1, DATA_BASE[15:4] + 12'(rand_bits(2))};
				prog[pc + 1] = {4'h6, 3'b000, (kind == 6), rd, lo};	// 6 is a store
				pc += 2;
			end else if (kind == 3 || kind == 4) begin
				if (rand_bits(1) && (pc < PROG_LEN - 1)) begin
					prog[pc] = {4'h1, 12'(rand_bits(12))};
					pc++;
				end
				prog[pc] = {4'h3, op, rd, lo};
				pc++;
			end else if (kind == 0) begin
				prog[pc] = NOP_INSTRUCTION;
				pc++;
			end else begin
				prog[pc] = {4'h2, op, rd, 1'b0, lo[2:0]};
				pc++;
			end
		end
	endtask

	task automatic expect_write(input logic [3:0] d, input word_t v);
		exp_wr_addr.push_back({1'b0, d});
		exp_wr_data.push_back(v);
	endtask

	// in-order ISA model, one instruction at a time
	task automatic run_model();
		word_t      regs [0:15];
		word_t      dmem [word_t];
		word_t      w;
		word_t      addr;
		imm_hi_t    prefix;
		logic [3:0] d;
		int         i;
		for (i = 0; i < 16; i++)
			regs[i] = rf[i];
		prefix = '0;
		for (i = 0; i < PROG_LEN; i++) begin
			w = prog[i];
			d = w[7:4];
			case (w[15:12])
				4'h1: prefix = w[11:0];
				4'h2: begin
					regs[d] = alu_calc(w[11:8], regs[d], regs[w[3:0]]);
					expect_write(d, regs[d]);
				end
				4'h3: begin
					regs[d] = alu_calc(w[11:8], regs[d], {prefix, w[3:0]});
					expect_write(d, regs[d]);
				end
				4'h6: begin
					addr = {prefix, w[3:0]};
					if (w[8]) begin
						dmem[addr] = regs[d];
						exp_st_addr.push_back(addr);
						exp_st_data.push_back(regs[d]);
					end else begin
						regs[d] = dmem.exists(addr) ? dmem[addr] : fill_word(addr);
						expect_write(d, regs[d]);
					end
				end
				default: ;
			endcase
			if ((w[15:12] != 4'h1) && (w != NOP_INSTRUCTION))
				prefix = '0;	// a prefix covers the next real instruction only
		end
	endtask

	always @(posedge CLK) begin
		alu_pipe <= alu_calc(alu_op, alu_a, alu_b);
		alu_out  <= alu_pipe;
	end

	always @(posedge CLK) begin
		if (mem_wr === 1'b1)
			mem[memory_addr] <= memory_out;
		if (mem_rd === 1'b1)
			memory_in <= mem[memory_addr];
	end

	always @(posedge CLK) begin
		if (reg_wr_addr != REG_NONE)
			rf[reg_wr_addr[3:0]] <= reg_wr_data;
	end

	always_comb begin
		if (reg_a_addr < 5'd16)
			reg_a = rf[reg_a_addr[3:0]];
		else
			reg_a = '0;
		if (reg_b_addr < 5'd16)
			reg_b = rf[reg_b_addr[3:0]];
		else
			reg_b = '0;
	end

	// write-back and store streams against the model
	always @(posedge CLK) begin
		if (RSTb) begin
			if (reg_wr_addr !== REG_NONE) begin
				if (exp_wr_addr.size() == 0) begin
					$display("register write seen after the model ran out of writes");
					stop_on_failure();
				end else begin
					check_reg_addr("reg_wr_addr", reg_wr_addr, exp_wr_addr.pop_front());
					check_word("reg_wr_data", reg_wr_data, exp_wr_data.pop_front());
				end
			end
			if (mem_wr !== 1'b0) begin
				if (exp_st_addr.size() == 0) begin
					$display("store seen after the model ran out of stores");
					stop_on_failure();
				end else begin
					check_word("memory_addr", memory_addr, exp_st_addr.pop_front());
					check_word("memory_out", memory_out, exp_st_data.pop_front());
				end
			end
		end
	end

	initial begin
		#(WATCHDOG);
		$display("watchdog expired before all writes and stores were seen");
		stop_on_failure();
	end

	initial begin
		int a;
		int n;
		RSTb = 1'b0;
		lfsr = 32'h250f9afd;
		for (n = 0; n < 16; n++)
			rf[n] = word_t'(rand_bits(16));
		build_program();
		for (a = 0; a < 65536; a++)
			mem[a] = ((a >= DATA_BASE) && (a < DATA_BASE + 256)) ? fill_word(word_t'(a))
			                                                     : NOP_INSTRUCTION;
		for (a = 0; a < PROG_LEN; a++)
			mem[a] = prog[a];
		run_model();

		@(posedge CLK);
		for (n = 1; n < RESET_CYCLES; n++) begin
			@(posedge CLK);
			check_reg_addr("reg_wr_addr", reg_wr_addr, REG_NONE);
			check_flag("mem_wr", mem_wr, 1'b0);
			check_flag("mem_rd", mem_rd, 1'b1);
		end
		RSTb <= 1'b1;

		while ((exp_wr_addr.size() != 0) || (exp_st_addr.size() != 0))
			@(posedge CLK);
		repeat (DRAIN_CYCLES) @(negedge CLK);	// catch late extra writes
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* pipeline16.f */
verilog/pipeline16_pkg.sv
verilog/pipeline16_stage_if.sv
verilog/pipeline16_decode.sv
verilog/pipeline16_interlock.sv
verilog/pipeline16_execute.sv
verilog/pipeline16_result.sv
verilog/pipeline16.sv
dv/pipeline16_tb.sv

/* Bender.yml */
package:
  name: pipeline16

sources:
  - verilog/pipeline16_pkg.sv
  - verilog/pipeline16_stage_if.sv
  - verilog/pipeline16_decode.sv
  - verilog/pipeline16_interlock.sv
  - verilog/pipeline16_execute.sv
  - verilog/pipeline16_result.sv
  - verilog/pipeline16.sv
  - target: test
    files:
      - dv/pipeline16_tb.sv
